// ==== common/mips_decode_pkg.sv ====
package mips_decode_pkg;

    typedef logic [31:0] word_t;    // instruction, pc or data word
    typedef logic [4:0]  reg_idx_t; // register file index

    localparam reg_idx_t REG_LINK = 5'd31; // jal writes its return address here

    localparam logic [5:0] OP_SPECIAL  = 6'h00; // R-type, selected by the function field
    localparam logic [5:0] OP_REGIMM   = 6'h01; // selected by the rt field
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_JAL      = 6'h03;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_BLEZ     = 6'h06;
    localparam logic [5:0] OP_BGTZ     = 6'h07;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c; // only mul is decoded from this group
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LH       = 6'h21;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_LHU      = 6'h25;
    localparam logic [5:0] OP_SB       = 6'h28;
    localparam logic [5:0] OP_SH       = 6'h29;
    localparam logic [5:0] OP_SW       = 6'h2b;

    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;
    localparam logic [5:0] FN_MUL   = 6'h02; // SPECIAL2 function code

    localparam logic [4:0] RT_BLTZ = 5'h00; // REGIMM codes carried in the rt field
    localparam logic [4:0] RT_BGEZ = 5'h01;

    typedef enum logic [1:0] {
        JP_NONE, JP_IMM, JP_REG // register jumps take the target from rs
    } jump_kind_e;

    typedef enum logic [1:0] {
        DST_RT, DST_RD, DST_LINK
    } dst_sel_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC // pc is written back by the link instructions
    } wb_src_e;

    typedef enum logic [1:0] {
        IMM_16, IMM_26, IMM_SA
    } imm_kind_e;

    typedef enum logic [1:0] {
        MEM_WORD, MEM_HALF, MEM_BYTE
    } mem_size_e;

    typedef enum logic [1:0] {
        HILO_ALU, HILO_HI, HILO_LO
    } hilo_sel_e;

    typedef struct packed {
        logic       br;        // conditional branch
        jump_kind_e jp;
        logic       alu_b_imm; // ALU B operand comes from the immediate
        logic       dm_we;     // data memory write
        logic       r_we;      // register file write
        dst_sel_e   r_dst;
        wb_src_e    wb_src;
        imm_kind_e  imm_kind;
        logic       imm_sext;  // sign extend the 16-bit immediate
        mem_size_e  mem_size;
        logic       mem_sext;  // sign extend the loaded value
        hilo_sel_e  hilo_out;
        logic       hi_we;
        logic       lo_we;
        logic       illegal;   // opcode or function not decoded
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dst_idx;
        word_t    imm;
        word_t    jump_target;
    } decoded_t;

endpackage

// ==== decode/decode_ctrl_table.sv ====
module decode_ctrl_table (
    input  mips_decode_pkg::word_t i_insn,
    output mips_decode_pkg::ctrl_t o_ctrl
);
    import mips_decode_pkg::*;

    logic [5:0] opcode; // primary opcode
    logic [5:0] funct;  // SPECIAL and SPECIAL2 function field
    logic [4:0] rt_f;   // REGIMM selects on rt

    assign opcode = i_insn[31:26];
    assign funct  = i_insn[5:0];
    assign rt_f   = i_insn[20:16];

    always_comb begin
        o_ctrl          = '0;   // every field starts cleared
        o_ctrl.imm_sext = 1'b1; // except the two extension flags which default to sign
        o_ctrl.mem_sext = 1'b1;

        if (i_insn != '0) begin // the all-zero word is a nop and keeps the defaults
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_SLL, FN_SRL, FN_SRA: begin
                            o_ctrl.alu_b_imm = 1'b1; // shift amount feeds ALU B
                            o_ctrl.r_we      = 1'b1;
                            o_ctrl.r_dst     = DST_RD;
                            o_ctrl.imm_kind  = IMM_SA;
                        end
                        FN_SLLV, FN_SRLV, FN_SRAV: begin
                            o_ctrl.r_we     = 1'b1; // amount comes from rs so B stays a register
                            o_ctrl.r_dst    = DST_RD;
                            o_ctrl.imm_kind = IMM_SA;
                        end
                        FN_JR: begin
                            o_ctrl.jp = JP_REG;
                        end
                        FN_JALR: begin
                            o_ctrl.jp     = JP_REG;
                            o_ctrl.r_we   = 1'b1;
                            o_ctrl.wb_src = WB_PC;  // link value goes to rd
                            o_ctrl.r_dst  = DST_RD;
                        end
                        FN_MFHI, FN_MFLO: begin
                            o_ctrl.r_we     = 1'b1;
                            o_ctrl.r_dst    = DST_RD;
                            o_ctrl.hilo_out = (funct == FN_MFHI) ? HILO_HI : HILO_LO;
                        end
                        FN_MTHI: begin
                            o_ctrl.hi_we = 1'b1;
                        end
                        FN_MTLO: begin
                            o_ctrl.lo_we = 1'b1;
                        end
                        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                            o_ctrl.hi_we = 1'b1; // product or quotient pair loads both halves
                            o_ctrl.lo_we = 1'b1;
                        end
                        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                        FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                            o_ctrl.r_we  = 1'b1; // three-register ALU ops write rd
                            o_ctrl.r_dst = DST_RD;
                        end
                        default: o_ctrl.illegal = 1'b1;
                    endcase
                end
                OP_REGIMM: begin
                    case (rt_f)
                        RT_BLTZ, RT_BGEZ: o_ctrl.br = 1'b1;
                        default:          o_ctrl.illegal = 1'b1;
                    endcase
                end
                OP_J, OP_JAL: begin
                    o_ctrl.jp       = JP_IMM;
                    o_ctrl.imm_kind = IMM_26;
                    if (opcode == OP_JAL) begin
                        o_ctrl.r_we   = 1'b1; // return address into r31
                        o_ctrl.r_dst  = DST_LINK;
                        o_ctrl.wb_src = WB_PC;
                    end
                end
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                    o_ctrl.br = 1'b1; // offset stays a signed 16-bit immediate
                end
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                    o_ctrl.alu_b_imm = 1'b1;
                    o_ctrl.r_we      = 1'b1;
                end
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    o_ctrl.alu_b_imm = 1'b1;
                    o_ctrl.r_we      = 1'b1;
                    o_ctrl.imm_sext  = 1'b0; // logical ops and lui zero extend
                end
                OP_SPECIAL2: begin
                    if (funct == FN_MUL) begin
                        o_ctrl.r_we  = 1'b1; // low product written straight to rd
                        o_ctrl.r_dst = DST_RD;
                    end else begin
                        o_ctrl.illegal = 1'b1;
                    end
                end
                OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                    o_ctrl.alu_b_imm = 1'b1; // address is rs plus offset
                    o_ctrl.r_we      = 1'b1;
                    o_ctrl.wb_src    = WB_MEM;
                    o_ctrl.mem_size  = (opcode == OP_LW) ? MEM_WORD :
                                       (opcode == OP_LH || opcode == OP_LHU) ? MEM_HALF :
                                       MEM_BYTE;
                    o_ctrl.mem_sext  = !(opcode == OP_LBU || opcode == OP_LHU);
                end
                OP_SB, OP_SH, OP_SW: begin
                    o_ctrl.alu_b_imm = 1'b1;
                    o_ctrl.dm_we     = 1'b1; // stores never write the register file
                    o_ctrl.mem_size  = (opcode == OP_SW) ? MEM_WORD :
                                       (opcode == OP_SH) ? MEM_HALF : MEM_BYTE;
                end
                default: o_ctrl.illegal = 1'b1;
            endcase
        end
    end

endmodule

// ==== decode/decode_operand_former.sv ====
module decode_operand_former (
    input  mips_decode_pkg::word_t    i_insn,
    input  mips_decode_pkg::word_t    i_pc,
    input  mips_decode_pkg::ctrl_t    i_ctrl,
    output mips_decode_pkg::reg_idx_t o_dst_idx,
    output mips_decode_pkg::word_t    o_imm,
    output mips_decode_pkg::word_t    o_jump_target
);
    import mips_decode_pkg::*;

    reg_idx_t    rt_f;    // second source or I-type destination
    reg_idx_t    rd_f;    // R-type destination
    logic [4:0]  sa_f;    // shift amount
    logic [15:0] imm16_f; // branch offset or ALU immediate
    logic [25:0] idx26_f; // jump index

    assign rt_f    = i_insn[20:16];
    assign rd_f    = i_insn[15:11];
    assign sa_f    = i_insn[10:6];
    assign imm16_f = i_insn[15:0];
    assign idx26_f = i_insn[25:0];

    always_comb begin
        case (i_ctrl.r_dst)
            DST_RD:   o_dst_idx = rd_f;
            DST_LINK: o_dst_idx = REG_LINK; // jal links through r31
            default:  o_dst_idx = rt_f;
        endcase
    end

    always_comb begin
        case (i_ctrl.imm_kind)
            IMM_26: o_imm = {6'd0, idx26_f};
            IMM_SA: o_imm = {27'd0, sa_f};
            default: begin
                if (i_ctrl.imm_sext) begin
                    o_imm = {{16{imm16_f[15]}}, imm16_f}; // replicate the offset sign bit
                end else begin
                    o_imm = {16'd0, imm16_f};
                end
            end
        endcase
    end

    // region jump stays inside the 256 MB segment of the current pc
    assign o_jump_target = {i_pc[31:28], idx26_f, 2'b00};

endmodule

// ==== flist.f ====
common/mips_decode_pkg.sv
decode/decode_ctrl_table.sv
decode/decode_operand_former.sv
verilog/pipe_skid_buffer.sv
verilog/mips_decode_stage.sv
testbench/tb_mips_decode_stage.sv

// ==== testbench/decode_cases.txt ====
// columns: insn pc ctrl dst_idx imm jump_target, all in hex
// ctrl bits 20..0: br jp[2] alu_b_imm dm_we r_we r_dst[2] wb_src[2] imm_kind[2] imm_sext mem_size[2] mem_sext hilo_out[2] hi_we lo_we illegal
00221820 00400000 0000A120 03 00001820 00886080 // add $3,$1,$2
00A6A027 00400004 0000A120 14 FFFFA027 029A809C // nor $20,$5,$6
00072140 00400008 0002A520 04 00000005 001C8500 // sll $4,$7,5
01AC5806 00400010 0000A520 0B 00000000 06B16018 // srlv $11,$12,$13
71F07002 00400014 0000A120 0E 00007002 07C1C008 // mul $14,$15,$16
2128FFFC 00400018 00028120 08 FFFFFFFC 04A3FFF0 // addi $8,$9,-4
2C628000 0040001C 00028120 02 FFFF8000 018A0000 // sltiu $2,$3,0x8000
30C5F0F0 00400020 00028020 05 0000F0F0 0317C3C0 // andi $5,$6,0xf0f0
3C078001 00400024 00028020 07 00008001 001E0004 // lui $7,0x8001
83A4FFFF 0040002C 000289A0 04 FFFFFFFF 0E93FFFC // lb $4,-1($29)
94A60008 00400030 00028940 06 00000008 02980020 // lhu $6,8($5)
8FA90010 00400034 00028920 09 00000010 0EA40040 // lw $9,16($29)
A462FFFE 00400038 00030160 02 FFFFFFFE 018BFFF8 // sh $2,-2($3)
08123456 A0001000 00040320 12 00123456 A048D158 // j with index 0x123456
0FFFFFFF 7FFFFFFC 0004D320 1F 03FFFFFF 7FFFFFFC // jal with index 0x3ffffff
03E00008 00400040 00080120 00 00000008 0F800020 // jr $31
0080F009 00400044 0008B120 1E FFFFF009 0203C024 // jalr $30,$4
1022FFF8 00400048 00100120 02 FFFFFFF8 008BFFE0 // beq $1,$2,-8
04610010 0040004C 00100120 01 00000010 01840040 // bgez $3,16
00001810 00400054 0000A128 03 00001810 00006040 // mfhi $3
00008812 00400058 0000A130 11 FFFF8812 00022048 // mflo $17
00800011 0040005C 00000124 00 00000011 02000044 // mthi $4
00A00013 00400060 00000122 00 00000013 0280004C // mtlo $5
00C7001B 00400064 00000126 07 0000001B 031C006C // divu $6,$7
FC221234 0040006C 00000121 02 00001234 008848D0 // opcode 0x3f is not decoded
00221801 00400070 00000121 02 00001801 00886004 // SPECIAL function 0x01 is not decoded
04510004 00400074 00000121 11 00000004 01440010 // REGIMM rt 0x11 is not decoded
00000000 0040007C 00000120 00 00000000 00000000 // all-zero word

// ==== testbench/tb_mips_decode_stage.sv ====
module tb_mips_decode_stage;
    import mips_decode_pkg::*;

    localparam int N_CASES    = 28;           // lines of data in the case file
    localparam int N_COLS     = 6;            // insn, pc, ctrl, dst_idx, imm, jump_target
    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 32'h9d3bd50e;

    logic       clk;
    logic       i_rst_n;
    logic       i_valid;
    logic       o_ready;
    word_t      i_insn;
    word_t      i_pc;
    logic       o_valid;
    logic       i_ready;
    word_t      o_pc;
    word_t      o_imm;
    word_t      o_jump_target;
    reg_idx_t   o_rs;
    reg_idx_t   o_rt;
    reg_idx_t   o_dst_idx;
    logic       o_br;
    jump_kind_e o_jp;
    logic       o_alu_b_imm;
    logic       o_dm_we;
    logic       o_r_we;
    dst_sel_e   o_r_dst;
    wb_src_e    o_wb_src;
    imm_kind_e  o_imm_kind;
    logic       o_imm_sext;
    mem_size_e  o_mem_size;
    logic       o_mem_sext;
    hilo_sel_e  o_hilo_out;
    logic       o_hi_we;
    logic       o_lo_we;
    logic       o_illegal;

    logic [31:0] cases_mem [0:N_CASES*N_COLS-1]; // flat image of the case file
    int          valid_seed;                     // idles on the input side
    int          ready_seed;                     // stalls on the output side

    mips_decode_stage i_mips_decode_stage (.*);

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin // x or z on an output counts as a mismatch too
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, actual,
                                     expected));
        end
    endtask

    task automatic compare_case(input int k);
        logic [31:0] insn;
        logic [31:0] ctrl;
        insn = cases_mem[k*N_COLS];
        ctrl = cases_mem[k*N_COLS+2];                       // packed from bit 20 down to illegal
        check_value("o_pc", o_pc, cases_mem[k*N_COLS+1]);   // a mismatch here means lost order
        check_value("o_rs", o_rs, insn[25:21]);
        check_value("o_rt", o_rt, insn[20:16]);
        check_value("o_dst_idx", o_dst_idx, cases_mem[k*N_COLS+3]);
        check_value("o_imm", o_imm, cases_mem[k*N_COLS+4]);
        check_value("o_jump_target", o_jump_target, cases_mem[k*N_COLS+5]);
        check_value("o_br", o_br, ctrl[20]);
        check_value("o_jp", o_jp, ctrl[19:18]);
        check_value("o_alu_b_imm", o_alu_b_imm, ctrl[17]);
        check_value("o_dm_we", o_dm_we, ctrl[16]);
        check_value("o_r_we", o_r_we, ctrl[15]);
        check_value("o_r_dst", o_r_dst, ctrl[14:13]);
        check_value("o_wb_src", o_wb_src, ctrl[12:11]);
        check_value("o_imm_kind", o_imm_kind, ctrl[10:9]);
        check_value("o_imm_sext", o_imm_sext, ctrl[8]);
        check_value("o_mem_size", o_mem_size, ctrl[7:6]);
        check_value("o_mem_sext", o_mem_sext, ctrl[5]);
        check_value("o_hilo_out", o_hilo_out, ctrl[4:3]);
        check_value("o_hi_we", o_hi_we, ctrl[2]);
        check_value("o_lo_we", o_lo_we, ctrl[1]);
        check_value("o_illegal", o_illegal, ctrl[0]);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(CLK_PERIOD * (8 + 4 * N_CASES + 20)); // reset, a generous four cycles per case, drain
        report_failure("timeout: the DUT did not deliver every case in time");
    end

    initial begin : drive_inputs
        int idx;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_insn     = '0;
        i_pc       = '0;
        i_ready    = 1'b0;
        valid_seed = SEED;
        $readmemh("testbench/decode_cases.txt", cases_mem);
        if ($isunknown(cases_mem[N_CASES*N_COLS-1])) begin
            report_failure("the case file holds fewer cases than the testbench expects");
        end
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;
        idx = 0;
        while (idx < N_CASES) begin
            @(posedge clk);
            if (i_valid && o_ready) begin
                idx = idx + 1; // the offered case was taken at this edge
            end
            if (!i_valid || o_ready) begin // a stalled offer must stay put
                if (idx < N_CASES && ($random(valid_seed) & 3) != 0) begin
                    i_valid <= 1'b1;
                    i_insn  <= cases_mem[idx*N_COLS];
                    i_pc    <= cases_mem[idx*N_COLS+1];
                end else begin
                    i_valid <= 1'b0; // idle about one cycle in four
                end
            end
        end
    end

    initial begin : check_outputs
        int n_seen;
        int n_extra;
        n_seen     = 0;
        n_extra    = 0;
        ready_seed = ~SEED;
        wait (i_rst_n === 1'b1);
        while (n_seen < N_CASES) begin
            @(posedge clk);
            if (o_valid && i_ready) begin
                compare_case(n_seen); // outputs sampled before this edge updates them
                n_seen = n_seen + 1;
            end
            i_ready <= ($random(ready_seed) & 1) != 0; // stall half the cycles to fill the skid
        end
        i_ready <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (o_valid) begin
                n_extra = n_extra + 1; // anything here was duplicated or invented
            end
        end
        if (n_seen == N_CASES && n_extra == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure("the DUT produced more outputs than cases were sent");
        end
    end

endmodule

// ==== verilog/mips_decode_stage.sv ====
module mips_decode_stage (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    output logic                        o_ready,
    input  mips_decode_pkg::word_t      i_insn,
    input  mips_decode_pkg::word_t      i_pc,
    output logic                        o_valid,
    input  logic                        i_ready,
    output mips_decode_pkg::word_t      o_pc,
    output mips_decode_pkg::word_t      o_imm,
    output mips_decode_pkg::word_t      o_jump_target,
    output mips_decode_pkg::reg_idx_t   o_rs,
    output mips_decode_pkg::reg_idx_t   o_rt,
    output mips_decode_pkg::reg_idx_t   o_dst_idx,
    output logic                        o_br,
    output mips_decode_pkg::jump_kind_e o_jp,
    output logic                        o_alu_b_imm,
    output logic                        o_dm_we,
    output logic                        o_r_we,
    output mips_decode_pkg::dst_sel_e   o_r_dst,
    output mips_decode_pkg::wb_src_e    o_wb_src,
    output mips_decode_pkg::imm_kind_e  o_imm_kind,
    output logic                        o_imm_sext,
    output mips_decode_pkg::mem_size_e  o_mem_size,
    output logic                        o_mem_sext,
    output mips_decode_pkg::hilo_sel_e  o_hilo_out,
    output logic                        o_hi_we,
    output logic                        o_lo_we,
    output logic                        o_illegal
);
    import mips_decode_pkg::*;

    ctrl_t    ctrl;        // control word for the instruction at the input
    reg_idx_t dst_idx;
    word_t    imm;
    word_t    jump_target;
    decoded_t dec_in;      // payload entering the buffer
    decoded_t dec_out;     // payload presented downstream

    decode_ctrl_table i_decode_ctrl_table (
        .i_insn (i_insn),
        .o_ctrl (ctrl)
    );

    decode_operand_former i_decode_operand_former (
        .i_insn        (i_insn),
        .i_pc          (i_pc),
        .i_ctrl        (ctrl),
        .o_dst_idx     (dst_idx),
        .o_imm         (imm),
        .o_jump_target (jump_target)
    );

    assign dec_in = '{ctrl: ctrl, pc: i_pc, rs: i_insn[25:21], rt: i_insn[20:16],
                       dst_idx: dst_idx, imm: imm, jump_target: jump_target};

    pipe_skid_buffer #(
        .payload_t (decoded_t)
    ) i_pipe_skid_buffer (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (dec_in),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (dec_out)
    );

    assign o_pc          = dec_out.pc;
    assign o_imm         = dec_out.imm;
    assign o_jump_target = dec_out.jump_target;
    assign o_rs          = dec_out.rs;
    assign o_rt          = dec_out.rt;
    assign o_dst_idx     = dec_out.dst_idx;
    assign o_br          = dec_out.ctrl.br;
    assign o_jp          = dec_out.ctrl.jp;
    assign o_alu_b_imm   = dec_out.ctrl.alu_b_imm;
    assign o_dm_we       = dec_out.ctrl.dm_we;
    assign o_r_we        = dec_out.ctrl.r_we;
    assign o_r_dst       = dec_out.ctrl.r_dst;
    assign o_wb_src      = dec_out.ctrl.wb_src;
    assign o_imm_kind    = dec_out.ctrl.imm_kind;
    assign o_imm_sext    = dec_out.ctrl.imm_sext;
    assign o_mem_size    = dec_out.ctrl.mem_size;
    assign o_mem_sext    = dec_out.ctrl.mem_sext;
    assign o_hilo_out    = dec_out.ctrl.hilo_out;
    assign o_hi_we       = dec_out.ctrl.hi_we;
    assign o_lo_we       = dec_out.ctrl.lo_we;
    assign o_illegal     = dec_out.ctrl.illegal;

endmodule

// ==== verilog/pipe_skid_buffer.sv ====
module pipe_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     main_valid;     // output register holds an item
    logic     skid_valid;     // overflow register holds an item
    payload_t main_data;
    payload_t skid_data;

    logic in_fire;            // input transfer this cycle
    logic out_fire;           // output transfer this cycle
    logic load_main_in;       // input goes straight to the output register
    logic load_main_skid;     // skid entry moves up to the output register
    logic load_skid;          // input parks because the output is stalled

    assign o_ready = !skid_valid; // taken straight from a flop so no path from i_ready
    assign o_valid = main_valid;
    assign o_data  = main_data;

    assign in_fire        = i_valid && o_ready;
    assign out_fire       = main_valid && i_ready;
    assign load_main_skid = skid_valid && i_ready;
    assign load_main_in   = in_fire && (!main_valid || i_ready);
    assign load_skid      = in_fire && main_valid && !i_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (load_main_in || load_main_skid) begin
                main_valid <= 1'b1;
            end else if (out_fire) begin
                main_valid <= 1'b0; // drained with nothing behind it
            end

            if (load_skid) begin
                skid_valid <= 1'b1; // second item held so the input closes next cycle
            end else if (load_main_skid) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_main_skid) begin
            main_data <= skid_data; // older item keeps its place in order
        end else if (load_main_in) begin
            main_data <= i_data;
        end

        if (load_skid) begin
            skid_data <= i_data;
        end
    end

endmodule
